/* all.f */
common/div_pkg.sv
divider/div_clz.sv
divider/div_step_counter.sv
divider/div_control.sv
divider/div_datapath.sv
source/div_req_queue.sv
source/div_unit_top.sv
tb/div_control_sva.sv
tb/div_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the divider testbench with Verilator, then look for the pass line.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module div_tb -f all.f -o div_sim \
    && ./obj_dir/div_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -qx ">>> PASS" sim.log && echo "Simulation passed" \
    || { echo "Simulation did not pass"; exit 1; }

/* tb/div_tb.sv */
`timescale 1ns/1ns

module div_tb;

    localparam int DATA_W      = div_pkg::DATA_W;
    localparam int TAG_W       = div_pkg::TAG_W;
    localparam int REQ_DEPTH   = 4;
    localparam int RSP_CREDITS = 2;
    localparam int CLK_PERIOD  = 40;
    localparam int HOLD_CYCLES = 3 * (DATA_W / 2 + 4);
    localparam int TEST_LEN    = 250 + HOLD_CYCLES;   // Requests over all tests plus held cycles
    localparam logic [DATA_W-1:0] MOST_NEG = {1'b1, {(DATA_W - 1){1'b0}}};

    logic              clk;
    logic              rst;
    logic              req_valid;
    div_pkg::div_op_e  req_op;
    logic [DATA_W-1:0] req_dividend;
    logic [DATA_W-1:0] req_divisor;
    logic [TAG_W-1:0]  req_tag;
    logic              req_credit;
    logic              rsp_valid;
    logic [DATA_W-1:0] rsp_quotient;
    logic [DATA_W-1:0] rsp_remainder;
    logic [TAG_W-1:0]  rsp_tag;
    logic              rsp_credit;

    div_pkg::div_rsp_t exp_q [$];               // Expected responses in request order
    logic [31:0]       lfsr = 32'h3ad6cbbc;
    logic              hold_credits = 1'b0;     // Downstream keeps its credits while set
    string             cur_test;
    int                req_credits = REQ_DEPTH;
    int                sent_count = 0;
    int                credit_pulses = 0;
    int                max_credit_lead = 0;     // Most request credits seen ahead of responses
    int                rsp_count = 0;
    int                pending_returns = 0;     // Credits owed back to the DUT
    int                err_count = 0;
    int                test_err_base = 0;
    int                tests_passed = 0;
    int                tests_failed = 0;

    div_unit_top #(
        .DATA_W      (DATA_W),
        .REQ_DEPTH   (REQ_DEPTH),
        .RSP_CREDITS (RSP_CREDITS)
    ) UUT (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_op        (req_op),
        .req_dividend  (req_dividend),
        .req_divisor   (req_divisor),
        .req_tag       (req_tag),
        .req_credit    (req_credit),
        .rsp_valid     (rsp_valid),
        .rsp_quotient  (rsp_quotient),
        .rsp_remainder (rsp_remainder),
        .rsp_tag       (rsp_tag),
        .rsp_credit    (rsp_credit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Fibonacci LFSR on x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[30:0], lfsr[0]};   // The new feedback bit
        end
    endtask

    // RISC-V division rules with the divide-by-zero and signed overflow cases
    function automatic div_pkg::div_rsp_t ref_divide(div_pkg::div_op_e op,
            logic [DATA_W-1:0] a, logic [DATA_W-1:0] b, logic [TAG_W-1:0] tag);
        div_pkg::div_rsp_t        r;
        logic signed [DATA_W-1:0] sa;
        logic signed [DATA_W-1:0] sb;
        sa    = a;
        sb    = b;
        r.tag = tag;
        if (b == '0) begin
            r.quotient  = '1;
            r.remainder = a;
        end else if (op == div_pkg::DIV_UNSIGNED) begin
            r.quotient  = a / b;
            r.remainder = a % b;
        end else if (a == MOST_NEG && b == '1) begin
            r.quotient  = MOST_NEG;
            r.remainder = '0;
        end else begin
            r.quotient  = sa / sb;    // Truncates toward zero
            r.remainder = sa % sb;
        end
        return r;
    endfunction

    task automatic check_word(string what, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("** Error in %s: %s expected %h, actual %h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_tag(logic [TAG_W-1:0] exp, logic [TAG_W-1:0] act);
        if (act !== exp) begin
            $display("** Error in %s: tag expected %h, actual %h", cur_test, exp, act);
            err_count++;
        end
    endtask

    task automatic check_count(string what, int exp, int act);
        if (act != exp) begin
            $display("** Error in %s: %s expected %0d, actual %0d", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    // Upstream credits and responses are sampled away from the clock edge
    always @(negedge clk) begin
        div_pkg::div_rsp_t exp;
        if (!rst) begin
            if (req_credit) begin
                credit_pulses++;
                req_credits++;
            end
            if (rsp_valid) begin
                rsp_count++;
                pending_returns++;
                if (exp_q.size() == 0) begin
                    $display("%s: a response arrived with no request pending", cur_test);
                    err_count++;
                end else begin
                    exp = exp_q.pop_front();
                    check_word("quotient", exp.quotient, rsp_quotient);
                    check_word("remainder", exp.remainder, rsp_remainder);
                    check_tag(exp.tag, rsp_tag);
                end
            end
            // Only the one division in flight may have freed its slot before its response
            if (credit_pulses - rsp_count > max_credit_lead) begin
                max_credit_lead = credit_pulses - rsp_count;
            end
        end
    end

    // Downstream hands back one credit per cycle unless told to hold them
    initial begin
        rsp_credit = 1'b0;
        forever begin
            @(posedge clk);
            #5;
            if (!hold_credits && pending_returns > 0) begin
                rsp_credit = 1'b1;
                pending_returns--;
            end else begin
                rsp_credit = 1'b0;
            end
        end
    end

    task automatic send_req(div_pkg::div_op_e op, logic [DATA_W-1:0] a,
            logic [DATA_W-1:0] b, logic [TAG_W-1:0] tag);
        @(posedge clk);
        #5;
        req_valid = 1'b0;
        while (req_credits == 0) begin
            @(posedge clk);
            #5;
        end
        req_valid    = 1'b1;
        req_op       = op;
        req_dividend = a;
        req_divisor  = b;
        req_tag      = tag;
        req_credits--;
        sent_count++;
        exp_q.push_back(ref_divide(op, a, b, tag));
    endtask

    task automatic wait_drain();
        @(posedge clk);
        #5;
        req_valid = 1'b0;
        while (exp_q.size() != 0 || (!hold_credits && pending_returns != 0)) begin
            @(negedge clk);
        end
    endtask

    task automatic start_test(string name);
        cur_test      = name;
        test_err_base = err_count;
    endtask

    task automatic end_test();
        if (err_count == test_err_base) begin
            tests_passed++;
            $display("%s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", cur_test, err_count - test_err_base);
        end
    endtask

    task automatic test_unsigned();
        logic [DATA_W-1:0] a [6];
        logic [DATA_W-1:0] b [6];
        start_test("unsigned");
        a = '{32'd100, 32'd7, 32'hffff_ffff, 32'hffff_ffff, 32'h8000_0000, 32'hdead_beef};
        b = '{32'd7, 32'd100, 32'd1, 32'hffff_ffff, 32'd3, 32'h0000_0010};
        for (int i = 0; i < 6; i++) begin
            send_req(div_pkg::DIV_UNSIGNED, a[i], b[i], TAG_W'(i));
        end
        wait_drain();
        end_test();
    endtask

    task automatic test_signed();
        logic [DATA_W-1:0] mag_a [2];
        logic [DATA_W-1:0] mag_b [2];
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        start_test("signed");
        mag_a = '{32'd100, 32'h7fff_ffff};
        mag_b = '{32'd7, 32'd12345};
        for (int p = 0; p < 2; p++) begin
            for (int s = 0; s < 4; s++) begin
                a = s[0] ? -mag_a[p] : mag_a[p];
                b = s[1] ? -mag_b[p] : mag_b[p];
                send_req(div_pkg::DIV_SIGNED, a, b, TAG_W'(4 * p + s));
            end
        end
        wait_drain();
        end_test();
    endtask

    task automatic test_special();
        start_test("special");
        send_req(div_pkg::DIV_SIGNED, 32'd12345, '0, 4'h1);
        send_req(div_pkg::DIV_UNSIGNED, 32'd12345, '0, 4'h2);
        send_req(div_pkg::DIV_SIGNED, MOST_NEG, '0, 4'h3);
        send_req(div_pkg::DIV_UNSIGNED, MOST_NEG, '0, 4'h4);
        send_req(div_pkg::DIV_UNSIGNED, '0, '0, 4'h5);
        send_req(div_pkg::DIV_SIGNED, MOST_NEG, '1, 4'h6);     // Signed overflow
        send_req(div_pkg::DIV_UNSIGNED, MOST_NEG, '1, 4'h7);
        wait_drain();
        end_test();
    endtask

    task automatic test_random();
        logic [31:0] op_bit;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] shift;
        int          base;
        start_test("random");
        base = rsp_count;
        for (int i = 0; i < 200; i++) begin
            take_bits(1, op_bit);
            take_bits(32, a);
            take_bits(32, b);
            take_bits(5, shift);
            b = b >> shift;         // Spread the divisor sizes so the step count varies
            send_req(op_bit[0] ? div_pkg::DIV_UNSIGNED : div_pkg::DIV_SIGNED, a, b, TAG_W'(i));
        end
        wait_drain();
        check_count("responses", 200, rsp_count - base);
        end_test();
    endtask

    task automatic test_backpressure();
        int base;
        start_test("backpressure");
        base         = rsp_count;
        hold_credits = 1'b1;
        for (int i = 0; i < 6; i++) begin
            send_req(div_pkg::DIV_UNSIGNED, 32'd5000 + 32'(i), 32'd3 + 32'(i), TAG_W'(8 + i));
        end
        @(posedge clk);
        #5;
        req_valid = 1'b0;
        repeat (HOLD_CYCLES) @(negedge clk);
        check_count("responses with credits held", RSP_CREDITS, rsp_count - base);
        hold_credits = 1'b0;
        wait_drain();
        check_count("responses after release", 6, rsp_count - base);
        end_test();
    endtask

    task automatic test_credits();
        start_test("credits");
        for (int i = 0; i < 12; i++) begin
            send_req(i[0] ? div_pkg::DIV_SIGNED : div_pkg::DIV_UNSIGNED,
                     32'(i * 1000 + 7), 32'(i + 1), TAG_W'(i));
        end
        wait_drain();
        check_count("request credit pulses", sent_count, credit_pulses);
        if (max_credit_lead > 1) begin
            $display("%s: request credits ran %0d ahead of responses with one division in flight",
                     cur_test, max_credit_lead);
            err_count++;
        end
        end_test();
    endtask

    initial begin
        rst          = 1'b1;
        req_valid    = 1'b0;
        req_op       = div_pkg::DIV_UNSIGNED;
        req_dividend = '0;
        req_divisor  = '0;
        req_tag      = '0;
        repeat (3) @(posedge clk);
        #5;
        rst = 1'b0;
        test_unsigned();
        test_signed();
        test_special();
        test_random();
        test_backpressure();
        test_credits();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Bound by the longest division per request
    initial begin
        #(TEST_LEN * (DATA_W / 2 + 4) * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* tb/div_control_sva.sv */
`timescale 1ns/1ns

module div_control_sva #(
    parameter int RSP_CREDITS = 2,
    parameter int CNT_W       = $clog2(RSP_CREDITS + 1)
) (
    input logic                clk,
    input logic                rst,
    input div_pkg::div_state_e state,
    input logic [CNT_W-1:0]    credit_cnt,
    input logic                q_pop,
    input logic                finish
);

    // Control leaves reset idle with no response beat on the port
    reset_idle: assert property (@(posedge clk) rst |=> (state == div_pkg::IDLE) && !finish)
        else $error("control is not idle in the cycle after reset");

    credit_bound: assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= CNT_W'(RSP_CREDITS))
        else $error("response credit count is above its reset value");

    // A pop spends a credit and starts one division, which must go through LOAD next
    pop_legal: assert property (@(posedge clk) disable iff (rst)
        q_pop |=> (state == div_pkg::LOAD) && !q_pop && ($past(credit_cnt) != '0))
        else $error("queue popped without a response credit or without starting a division");

endmodule

bind div_control div_control_sva #(.RSP_CREDITS(RSP_CREDITS)) u_control_sva (
    .clk        (clk),
    .rst        (rst),
    .state      (state),
    .credit_cnt (credit_cnt),
    .q_pop      (q_pop),
    .finish     (finish)
);

/* source/div_unit_top.sv */
`timescale 1ns/1ns

module div_unit_top #(
    parameter int DATA_W      = div_pkg::DATA_W,
    parameter int REQ_DEPTH   = 4,
    parameter int RSP_CREDITS = 2
) (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      req_valid,
    input  div_pkg::div_op_e          req_op,
    input  logic [DATA_W-1:0]         req_dividend,
    input  logic [DATA_W-1:0]         req_divisor,
    input  logic [div_pkg::TAG_W-1:0] req_tag,
    output logic                      req_credit,

    output logic                      rsp_valid,
    output logic [DATA_W-1:0]         rsp_quotient,
    output logic [DATA_W-1:0]         rsp_remainder,
    output logic [div_pkg::TAG_W-1:0] rsp_tag,
    input  logic                      rsp_credit
);

    div_pkg::div_req_t          req_word;
    div_pkg::div_req_t          q_head;
    logic                       q_empty;
    logic                       q_pop;
    logic                       load;
    logic                       iterate;
    logic                       early_exit;
    logic                       last_step;
    logic [div_pkg::CLZ_W-2:0]  step_count;

    assign req_word = '{
        op:       req_op,
        dividend: req_dividend,
        divisor:  req_divisor,
        tag:      req_tag
    };

    div_req_queue #(.REQ_DEPTH(REQ_DEPTH)) u_queue (
        .clk           (clk),
        .rst           (rst),
        .push          (req_valid),
        .push_data     (req_word),
        .pop           (q_pop),
        .head          (q_head),
        .empty         (q_empty),
        .credit_return (req_credit)
    );

    div_control #(.RSP_CREDITS(RSP_CREDITS)) u_control (
        .clk        (clk),
        .rst        (rst),
        .q_empty    (q_empty),
        .early_exit (early_exit),
        .last_step  (last_step),
        .rsp_credit (rsp_credit),
        .q_pop      (q_pop),
        .load       (load),
        .iterate    (iterate),
        .finish     (rsp_valid)   // FINISH cycle is the response beat
    );

    div_step_counter u_step_counter (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .iterate    (iterate),
        .step_count (step_count),
        .last_step  (last_step)
    );

    div_datapath #(.DATA_W(DATA_W)) u_datapath (
        .clk        (clk),
        .load       (load),
        .iterate    (iterate),
        .finish     (rsp_valid),
        .q_op       (q_head.op),
        .q_dividend (q_head.dividend),
        .q_divisor  (q_head.divisor),
        .q_tag      (q_head.tag),
        .early_exit (early_exit),
        .step_count (step_count),
        .quotient   (rsp_quotient),
        .remainder  (rsp_remainder),
        .tag        (rsp_tag)
    );

endmodule

/* source/div_req_queue.sv */
`timescale 1ns/1ns

module div_req_queue #(
    parameter int REQ_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  div_pkg::div_req_t push_data,
    input  logic              pop,
    output div_pkg::div_req_t head,
    output logic              empty,
    output logic              credit_return
);

    localparam int PTR_W = $clog2(REQ_DEPTH);
    localparam int CNT_W = $clog2(REQ_DEPTH + 1);

    div_pkg::div_req_t mem [REQ_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;

    // Upstream credits guarantee a free slot on every push
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // The popped entry is registered, so it sits on head during the cycle after the pop
    always_ff @(posedge clk) begin
        if (pop) begin
            head <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            credit_return <= pop;  // One slot freed, one credit back to upstream
        end
    end

    assign empty = (count == '0);

endmodule

/* divider/div_datapath.sv */
`timescale 1ns/1ns

module div_datapath #(
    parameter int DATA_W = div_pkg::DATA_W
) (
    input  logic                      clk,
    input  logic                      load,
    input  logic                      iterate,
    input  logic                      finish,
    input  div_pkg::div_op_e          q_op,
    input  logic [DATA_W-1:0]         q_dividend,
    input  logic [DATA_W-1:0]         q_divisor,
    input  logic [div_pkg::TAG_W-1:0] q_tag,
    output logic                      early_exit,
    output logic [div_pkg::CLZ_W-2:0] step_count,
    output logic [DATA_W-1:0]         quotient,
    output logic [DATA_W-1:0]         remainder,
    output logic [div_pkg::TAG_W-1:0] tag
);

    localparam int CLZ_W = div_pkg::CLZ_W;

    logic                      dividend_neg;
    logic                      divisor_neg;
    logic                      divisor_zero;
    logic [DATA_W-1:0]         abs_dividend;
    logic [DATA_W-1:0]         abs_divisor;
    logic [CLZ_W-1:0]          dividend_clz;
    logic [CLZ_W-1:0]          divisor_clz;
    logic [CLZ_W-1:0]          clz_delta;
    logic                      clz_borrow;

    logic [DATA_W-1:0]         div_q;       // Aligned divisor, moves right two bits per step
    logic [DATA_W-1:0]         rem_q;       // Partial remainder
    logic [DATA_W-1:0]         quot_q;
    logic                      neg_quot_q;
    logic                      neg_rem_q;
    logic                      div_zero_q;
    logic [div_pkg::TAG_W-1:0] tag_q;

    logic [DATA_W+1:0]         diff_2x;
    logic [DATA_W:0]           diff_1x;
    logic                      q_hi;
    logic                      q_lo;
    logic [DATA_W-1:0]         rem_mid;
    logic [DATA_W-1:0]         rem_next;
    logic [DATA_W-1:0]         quot_fixed;
    logic [DATA_W-1:0]         rem_fixed;

    assign dividend_neg = (q_op == div_pkg::DIV_SIGNED) && q_dividend[DATA_W-1];
    assign divisor_neg  = (q_op == div_pkg::DIV_SIGNED) && q_divisor[DATA_W-1];
    assign divisor_zero = (q_divisor == '0);

    assign abs_dividend = dividend_neg ? ~q_dividend + 1'b1 : q_dividend;
    assign abs_divisor  = divisor_neg ? ~q_divisor + 1'b1 : q_divisor;

    div_clz #(.DATA_W(DATA_W)) u_dividend_clz (
        .value (abs_dividend),
        .count (dividend_clz)
    );

    div_clz #(.DATA_W(DATA_W)) u_divisor_clz (
        .value (abs_divisor),
        .count (divisor_clz)
    );

    // Borrow means the divisor has more significant bits, so the quotient is zero
    assign {clz_borrow, clz_delta} = {1'b0, divisor_clz} - {1'b0, dividend_clz};

    assign early_exit = divisor_zero | clz_borrow;
    assign step_count = clz_delta[CLZ_W-1:1];   // One step per two bits, plus the final one

    // Restoring radix-4 step: try twice the divisor, then once, on what is left
    assign diff_2x  = {2'b00, rem_q} - {1'b0, div_q, 1'b0};
    assign q_hi     = ~diff_2x[DATA_W+1];
    assign rem_mid  = q_hi ? diff_2x[DATA_W-1:0] : rem_q;
    assign diff_1x  = {1'b0, rem_mid} - {1'b0, div_q};
    assign q_lo     = ~diff_1x[DATA_W];
    assign rem_next = q_lo ? diff_1x[DATA_W-1:0] : rem_mid;

    always_ff @(posedge clk) begin
        if (load) begin
            tag_q      <= q_tag;
            neg_quot_q <= dividend_neg ^ divisor_neg;
            neg_rem_q  <= dividend_neg;
            div_zero_q <= divisor_zero;
            // Even shift keeps the start remainder below four times the divisor
            div_q      <= abs_divisor << {clz_delta[CLZ_W-1:1], 1'b0};
            rem_q      <= abs_dividend;
            quot_q     <= '0;
        end else if (iterate) begin
            div_q  <= {2'b00, div_q[DATA_W-1:2]};
            rem_q  <= rem_next;
            quot_q <= {quot_q[DATA_W-3:0], q_hi, q_lo};
        end
    end

    // Quotient takes the sign of the product of signs, remainder that of the dividend.
    // For a zero divisor the remainder register still holds |dividend|, so the sign
    // correction gives back the dividend itself
    assign quot_fixed = div_zero_q ? '1 : (neg_quot_q ? ~quot_q + 1'b1 : quot_q);
    assign rem_fixed  = neg_rem_q ? ~rem_q + 1'b1 : rem_q;

    // Result bus stays quiet outside FINISH so downstream never sees partial values
    assign quotient  = finish ? quot_fixed : '0;
    assign remainder = finish ? rem_fixed : '0;
    assign tag       = finish ? tag_q : '0;

endmodule

/* divider/div_control.sv */
`timescale 1ns/1ns

module div_control #(
    parameter int RSP_CREDITS = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic q_empty,
    input  logic early_exit,
    input  logic last_step,
    input  logic rsp_credit,
    output logic q_pop,
    output logic load,
    output logic iterate,
    output logic finish
);

    localparam int CNT_W = $clog2(RSP_CREDITS + 1);

    div_pkg::div_state_e state;
    div_pkg::div_state_e state_next;
    logic [CNT_W-1:0]    credit_cnt;    // Response slots downstream still has free
    logic                launch;

    // A division starts only with work queued and room downstream for its result
    assign launch = (state == div_pkg::IDLE) && !q_empty && (credit_cnt != '0);

    assign q_pop   = launch;
    assign load    = (state == div_pkg::LOAD);
    assign iterate = (state == div_pkg::RUN);
    assign finish  = (state == div_pkg::FINISH);

    always_comb begin
        state_next = state;
        case (state)
            div_pkg::IDLE: begin
                if (launch) begin
                    state_next = div_pkg::LOAD;
                end
            end
            div_pkg::LOAD: begin
                // Zero divisor or divisor above dividend needs no iteration
                state_next = early_exit ? div_pkg::FINISH : div_pkg::RUN;
            end
            div_pkg::RUN: begin
                if (last_step) begin
                    state_next = div_pkg::FINISH;
                end
            end
            default: state_next = div_pkg::IDLE;  // FINISH lasts a single cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= div_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= CNT_W'(RSP_CREDITS);
        end else if (launch && !rsp_credit) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!launch && rsp_credit) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
        // A launch and a returned credit in the same cycle leave the count as it is
    end

endmodule

/* divider/div_step_counter.sv */
`timescale 1ns/1ns

module div_step_counter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load,
    input  logic                      iterate,
    input  logic [div_pkg::CLZ_W-2:0] step_count,
    output logic                      last_step
);

    logic [div_pkg::CLZ_W-2:0] steps_left;

    // Holds the number of radix-4 steps still to run after the current one
    always_ff @(posedge clk) begin
        if (rst) begin
            steps_left <= '0;
        end else if (load) begin
            steps_left <= step_count;
        end else if (iterate) begin
            steps_left <= steps_left - 1'b1;  // Wraps once after the last step, never read then
        end
    end

    assign last_step = (steps_left == '0);

endmodule

/* divider/div_clz.sv */
`timescale 1ns/1ns

module div_clz #(
    parameter int DATA_W = div_pkg::DATA_W
) (
    input  logic [DATA_W-1:0]         value,
    output logic [div_pkg::CLZ_W-1:0] count
);

    logic [DATA_W-1:0] norm;

    // Normalizing tree: at each level check whether the upper slice is all zero,
    // and if so record that bit of the count and shift the slice out.
    // Level widths halve from DATA_W/2 down to 1, which keeps the depth at CLZ_W
    always_comb begin
        norm  = value;
        count = '0;
        for (int lvl = div_pkg::CLZ_W - 1; lvl >= 0; lvl--) begin
            if ((norm >> (DATA_W - (1 << lvl))) == '0) begin
                count[lvl] = 1'b1;
                norm       = norm << (1 << lvl);
            end
        end
    end

    // A zero input saturates at DATA_W-1, which the datapath treats the same as a value of one

endmodule

/* common/div_pkg.sv */
package div_pkg;

    // Operand and result width of the unit
    localparam int DATA_W = 32;

    localparam int TAG_W = 4;   // Tag travels with the request and comes back with its result

    // Width of a leading-zero count for one operand
    localparam int CLZ_W = $clog2(DATA_W);

    typedef enum logic {
        DIV_SIGNED   = 1'b0,
        DIV_UNSIGNED = 1'b1
    } div_op_e;

    // One queued division request
    typedef struct packed {
        div_op_e           op;
        logic [DATA_W-1:0] dividend;
        logic [DATA_W-1:0] divisor;
        logic [TAG_W-1:0]  tag;
    } div_req_t;

    // One finished division, as seen on the response port
    typedef struct packed {
        logic [DATA_W-1:0] quotient;
        logic [DATA_W-1:0] remainder;
        logic [TAG_W-1:0]  tag;
    } div_rsp_t;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,  // Waiting for a request and a response credit
        LOAD   = 2'd1,  // Operands captured, divisor aligned
        RUN    = 2'd2,  // Two quotient bits per cycle
        FINISH = 2'd3   // Corrected result on the response port
    } div_state_e;

endpackage
